//--- src/scara_pkg.sv
// SCARA motion package with command word layout, opcodes and joint types
package scara_pkg;

	// ==============================
	// Field widths
	// ==============================

	// Full stream word toward and from the host
	localparam int WORD_W   = 32;
	localparam int OPCODE_W = 4;
	// Signed magnitude axis value
	localparam int AXIS_W   = 14;
	// Magnitude part of an axis value
	localparam int STEP_W   = 13;
	// Joint position counter
	localparam int POS_W    = 16;

	// ==============================
	// Types
	// ==============================

	// Command and response share one layout
	typedef logic [WORD_W-1:0] cmd_word_t;
	typedef logic [OPCODE_W-1:0] opcode_t;
	typedef logic [AXIS_W-1:0] axis_value_t;
	typedef logic [STEP_W-1:0] step_count_t;
	typedef logic signed [POS_W-1:0] position_t;

	// ==============================
	// Opcodes
	// ==============================

	// Step both joints by their axis values
	localparam opcode_t OP_MOVE   = 4'd1;
	// Clear both position counters
	localparam opcode_t OP_ZERO   = 4'd2;
	// Returned in place of any unknown opcode
	localparam opcode_t OP_REJECT = 4'd15;

	// ==============================
	// Field positions in the word
	// ==============================

	localparam int OPCODE_LSB   = 0;
	// Joint 1 axis in bits 17..4
	localparam int AXIS1_LSB    = 4;
	// Joint 2 axis in bits 31..18
	localparam int AXIS2_LSB    = 18;
	// Direction bit inside an axis value, set means negative
	localparam int AXIS_DIR_BIT = 13;

endpackage : scara_pkg

//--- src/stepper_joint.sv
// Stepper joint producing step and direction pulses and tracking its signed position
`timescale 1ns/10ps

module stepper_joint #(
	parameter int STEP_HALF_PERIOD = 4
) (
	input  logic                  CLOCK_50,
	input  logic                  rst_n,
	input  logic                  start,
	input  logic                  clear,
	input  scara_pkg::step_count_t steps,
	input  logic                  dir,
	output logic                  step,
	output logic                  dir_pin,
	output logic                  busy,
	output scara_pkg::position_t  position
);

	import scara_pkg::*;

	// ==============================
	// Phase timer sizing
	// ==============================

	// Timer runs 0 .. STEP_HALF_PERIOD-1 in each phase
	localparam int TIMER_W = (STEP_HALF_PERIOD > 1) ? $clog2(STEP_HALF_PERIOD) : 1;
	localparam logic [TIMER_W-1:0] HALF_LAST = TIMER_W'(STEP_HALF_PERIOD - 1);

	// Steps still to finish, including the one in progress
	step_count_t remaining;
	logic [TIMER_W-1:0] phase_timer;
	logic phase_done;
	logic launch;

	// Last cycle of the current high or low phase
	assign phase_done = (phase_timer == HALF_LAST);

	// New move only from idle and only with a nonzero count
	assign launch = start && !busy && (steps != '0);

	// ==============================
	// Step waveform
	// ==============================

	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			busy        <= 1'b0;
			step        <= 1'b0;
			dir_pin     <= 1'b0;
			remaining   <= '0;
			phase_timer <= '0;
		end else if (launch) begin
			// High phase begins on the same edge as busy
			busy        <= 1'b1;
			step        <= 1'b1;
			dir_pin     <= dir;
			remaining   <= steps;
			phase_timer <= '0;
		end else if (busy) begin
			if (phase_done) begin
				phase_timer <= '0;
				if (step) begin
					// High phase over
					step <= 1'b0;
				end else if (remaining == step_count_t'(1)) begin
					// Last low phase over
					busy      <= 1'b0;
					remaining <= '0;
				end else begin
					// Next step starts
					remaining <= remaining - step_count_t'(1);
					step      <= 1'b1;
				end
			end else begin
				phase_timer <= phase_timer + 1'b1;
			end
		end
	end

	// ==============================
	// Position counter
	// ==============================

	// Counts on the edge that ends each high phase
	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			position <= '0;
		end else if (clear) begin
			position <= '0;
		end else if (busy && step && phase_done) begin
			if (dir_pin) begin
				position <= position - position_t'(1);
			end else begin
				position <= position + position_t'(1);
			end
		end
	end

endmodule : stepper_joint

//--- src/move_sequencer.sv
// Command sequencer that accepts words, dispatches both joints and returns a response
`timescale 1ns/10ps

module move_sequencer (
	input  logic                   CLOCK_50,
	input  logic                   rst_n,

	// Command stream from host
	input  scara_pkg::cmd_word_t   cmd_data,
	input  logic                   cmd_valid,
	output logic                   cmd_ready,

	// Response stream to host
	output scara_pkg::cmd_word_t   rsp_data,
	output logic                   rsp_valid,
	input  logic                   rsp_ready,

	// Shared joint controls
	output logic                   joint_start,
	output logic                   joint_clear,

	// Per joint move request and status
	output scara_pkg::step_count_t joint1_steps,
	output logic                   joint1_dir,
	input  logic                   joint1_busy,
	output scara_pkg::step_count_t joint2_steps,
	output logic                   joint2_dir,
	input  logic                   joint2_busy
);

	import scara_pkg::*;

	// ==============================
	// State and held word
	// ==============================

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DISPATCH,
		ST_WAIT,
		ST_RESPOND
	} seq_state_t;

	seq_state_t state;

	// Accepted word with the opcode already fixed up for the response
	cmd_word_t held_word;

	opcode_t in_opcode;
	logic in_known;
	logic accept;
	logic joints_idle;
	axis_value_t axis1;
	axis_value_t axis2;

	// ==============================
	// Incoming word decode
	// ==============================

	assign in_opcode = cmd_data[OPCODE_LSB +: OPCODE_W];
	assign in_known  = (in_opcode == OP_MOVE) || (in_opcode == OP_ZERO);

	// Transfer on a valid and ready edge
	assign cmd_ready = (state == ST_IDLE);
	assign accept    = cmd_valid && cmd_ready;

	assign joints_idle = !joint1_busy && !joint2_busy;

	// ==============================
	// Sequencer FSM
	// ==============================

	always_ff @(posedge CLOCK_50) begin
		if (!rst_n) begin
			state       <= ST_IDLE;
			joint_start <= 1'b0;
			joint_clear <= 1'b0;
		end else begin
			// Start and clear are single cycle pulses
			joint_start <= 1'b0;
			joint_clear <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (accept) begin
						joint_start <= (in_opcode == OP_MOVE);
						joint_clear <= (in_opcode == OP_ZERO);
						state       <= ST_DISPATCH;
					end
				end
				// Pulse cycle, joints see start or clear here
				ST_DISPATCH: begin
					state <= ST_WAIT;
				end
				// Busy is valid from here on
				ST_WAIT: begin
					if (joints_idle) begin
						state <= ST_RESPOND;
					end
				end
				// Hold response until the sink takes it
				ST_RESPOND: begin
					if (rsp_ready) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// ==============================
	// Held word and response
	// ==============================

	always_ff @(posedge CLOCK_50) begin
		if (accept) begin
			held_word <= cmd_data;
			// Unknown opcodes come back marked as rejected
			if (!in_known) begin
				held_word[OPCODE_LSB +: OPCODE_W] <= OP_REJECT;
			end
		end
	end

	// Stable through back-pressure since held_word loads only in idle
	assign rsp_data  = held_word;
	assign rsp_valid = (state == ST_RESPOND);

	// Axis fields of the held word
	assign axis1 = held_word[AXIS1_LSB +: AXIS_W];
	assign axis2 = held_word[AXIS2_LSB +: AXIS_W];

	// Magnitude and direction per joint
	assign joint1_steps = axis1[STEP_W-1:0];
	assign joint1_dir   = axis1[AXIS_DIR_BIT];
	assign joint2_steps = axis2[STEP_W-1:0];
	assign joint2_dir   = axis2[AXIS_DIR_BIT];

endmodule : move_sequencer

//--- src/scara_motion_top.sv
// SCARA motion top level joining the command sequencer to two stepper joints
`timescale 1ns/10ps

module scara_motion_top #(
	parameter int STEP_HALF_PERIOD = 4
) (
	input  logic                 CLOCK_50,
	input  logic                 rst_n,

	// Command stream in
	input  scara_pkg::cmd_word_t cmd_data,
	input  logic                 cmd_valid,
	output logic                 cmd_ready,

	// Response stream out
	output scara_pkg::cmd_word_t rsp_data,
	output logic                 rsp_valid,
	input  logic                 rsp_ready,

	// Joint 1 driver pins and position
	output logic                 joint1_step,
	output logic                 joint1_dir,
	output scara_pkg::position_t joint1_position,

	// Joint 2 driver pins and position
	output logic                 joint2_step,
	output logic                 joint2_dir,
	output scara_pkg::position_t joint2_position
);

	import scara_pkg::*;

	// ==============================
	// Sequencer to joint wiring
	// ==============================

	logic joint_start;
	logic joint_clear;
	step_count_t joint1_steps;
	step_count_t joint2_steps;
	// Requested direction, latched by each joint at start
	logic joint1_dir_req;
	logic joint2_dir_req;
	logic joint1_busy;
	logic joint2_busy;

	move_sequencer i_move_sequencer (
		.CLOCK_50     (CLOCK_50),
		.rst_n        (rst_n),
		.cmd_data     (cmd_data),
		.cmd_valid    (cmd_valid),
		.cmd_ready    (cmd_ready),
		.rsp_data     (rsp_data),
		.rsp_valid    (rsp_valid),
		.rsp_ready    (rsp_ready),
		.joint_start  (joint_start),
		.joint_clear  (joint_clear),
		.joint1_steps (joint1_steps),
		.joint1_dir   (joint1_dir_req),
		.joint1_busy  (joint1_busy),
		.joint2_steps (joint2_steps),
		.joint2_dir   (joint2_dir_req),
		.joint2_busy  (joint2_busy)
	);

	// ==============================
	// Joints
	// ==============================

	// Both joints run from the shared start and clear pulses
	stepper_joint #(
		.STEP_HALF_PERIOD (STEP_HALF_PERIOD)
	) joint1 (
		.CLOCK_50 (CLOCK_50),
		.rst_n    (rst_n),
		.start    (joint_start),
		.clear    (joint_clear),
		.steps    (joint1_steps),
		.dir      (joint1_dir_req),
		.step     (joint1_step),
		.dir_pin  (joint1_dir),
		.busy     (joint1_busy),
		.position (joint1_position)
	);

	stepper_joint #(
		.STEP_HALF_PERIOD (STEP_HALF_PERIOD)
	) joint2 (
		.CLOCK_50 (CLOCK_50),
		.rst_n    (rst_n),
		.start    (joint_start),
		.clear    (joint_clear),
		.steps    (joint2_steps),
		.dir      (joint2_dir_req),
		.step     (joint2_step),
		.dir_pin  (joint2_dir),
		.busy     (joint2_busy),
		.position (joint2_position)
	);

endmodule : scara_motion_top

//--- testbench/tb_clock_gen.sv
// Testbench clock and reset source with a 100 ns clock and a short synchronous reset
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int HALF_PERIOD_NS = 50,
	parameter int RESET_CYCLES   = 3
) (
	output logic CLOCK_50,
	output logic rst_n
);

	// Free running clock, low at time zero
	initial begin
		CLOCK_50 = 1'b0;
		forever begin
			#(HALF_PERIOD_NS) CLOCK_50 = ~CLOCK_50;
		end
	end

	// Low over the first rising edges, released on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLOCK_50);
		@(negedge CLOCK_50);
		rst_n = 1'b1;
	end

endmodule : tb_clock_gen

//--- testbench/tb_scara_motion_top.sv
// Testbench for the SCARA motion top level, runs a command table through the stream ports
`timescale 1ns/10ps

module tb_scara_motion_top;

	import scara_pkg::*;

	// ==============================
	// Constants and signals
	// ==============================

	localparam int NUM_ENTRIES   = 10;
	localparam int RESET_TIMEOUT = 20;
	localparam int READY_TIMEOUT = 50;
	// Longest move is 12 steps of 4 cycles
	localparam int RSP_TIMEOUT   = 400;
	localparam logic [31:0] LFSR_SEED = 32'hcc11_5651;

	logic CLOCK_50;
	logic rst_n;
	cmd_word_t cmd_data;
	logic cmd_valid;
	logic cmd_ready;
	cmd_word_t rsp_data;
	logic rsp_valid;
	logic rsp_ready;
	logic joint1_step;
	logic joint1_dir;
	position_t joint1_position;
	logic joint2_step;
	logic joint2_dir;
	position_t joint2_position;

	// Table columns, one row per command
	cmd_word_t tbl_cmd [NUM_ENTRIES];
	cmd_word_t tbl_rsp [NUM_ENTRIES];
	int tbl_pos1 [NUM_ENTRIES];
	int tbl_pos2 [NUM_ENTRIES];
	int tbl_steps1 [NUM_ENTRIES];
	int tbl_steps2 [NUM_ENTRIES];

	int checks = 0;
	int errors = 0;
	logic timed_out = 1'b0;
	logic [31:0] lfsr_state;

	// Step pulse monitor
	int pulse_count1 = 0;
	int pulse_count2 = 0;
	logic step1_prev = 1'b0;
	logic step2_prev = 1'b0;
	logic exp_dir1;
	logic exp_dir2;

	tb_clock_gen i_tb_clock_gen (
		.CLOCK_50 (CLOCK_50),
		.rst_n    (rst_n)
	);

	scara_motion_top #(
		.STEP_HALF_PERIOD (2)
	) i_scara_motion_top (
		.CLOCK_50        (CLOCK_50),
		.rst_n           (rst_n),
		.cmd_data        (cmd_data),
		.cmd_valid       (cmd_valid),
		.cmd_ready       (cmd_ready),
		.rsp_data        (rsp_data),
		.rsp_valid       (rsp_valid),
		.rsp_ready       (rsp_ready),
		.joint1_step     (joint1_step),
		.joint1_dir      (joint1_dir),
		.joint1_position (joint1_position),
		.joint2_step     (joint2_step),
		.joint2_dir      (joint2_dir),
		.joint2_position (joint2_position)
	);

	// ==============================
	// Helpers
	// ==============================

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// One LFSR step per bit taken
	task automatic draw_bits(input int width, output int value);
		value = 0;
		for (int b = 0; b < width; b++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	// Command word from opcode and two signed magnitude axes
	function automatic cmd_word_t make_word(input opcode_t op, input logic dir1, input int mag1,
			input logic dir2, input int mag2);
		cmd_word_t w;
		w = '0;
		w[OPCODE_LSB +: OPCODE_W] = op;
		w[AXIS1_LSB +: STEP_W] = step_count_t'(mag1);
		w[AXIS1_LSB + AXIS_DIR_BIT] = dir1;
		w[AXIS2_LSB +: STEP_W] = step_count_t'(mag2);
		w[AXIS2_LSB + AXIS_DIR_BIT] = dir2;
		return w;
	endfunction

	function automatic cmd_word_t with_opcode(input cmd_word_t w, input opcode_t op);
		cmd_word_t r;
		r = w;
		r[OPCODE_LSB +: OPCODE_W] = op;
		return r;
	endfunction

	task automatic check_value(input string name, input logic [31:0] observed,
			input logic [31:0] expected);
		checks++;
		if (observed !== expected) begin
			errors++;
			$display("FAIL %s: got 0x%h, expected 0x%h at %0t", name, observed, expected, $time);
		end
	endtask

	task automatic set_entry(input int idx, input cmd_word_t cmd, input cmd_word_t rsp,
			input int pos1, input int pos2, input int steps1, input int steps2);
		tbl_cmd[idx]    = cmd;
		tbl_rsp[idx]    = rsp;
		tbl_pos1[idx]   = pos1;
		tbl_pos2[idx]   = pos2;
		tbl_steps1[idx] = steps1;
		tbl_steps2[idx] = steps2;
	endtask

	// Positions accumulate from row to row
	task automatic fill_table();
		cmd_word_t w;
		w = make_word(OP_MOVE, 1'b0, 5, 1'b0, 3);
		set_entry(0, w, w, 5, 3, 5, 3);
		// Joint 2 axis with zero steps
		w = make_word(OP_MOVE, 1'b1, 2, 1'b0, 0);
		set_entry(1, w, w, 3, 3, 2, 0);
		w = make_word(OP_MOVE, 1'b0, 0, 1'b1, 7);
		set_entry(2, w, w, 3, -4, 0, 7);
		// Unknown opcode 5
		w = make_word(4'd5, 1'b0, 4, 1'b0, 4);
		set_entry(3, w, with_opcode(w, OP_REJECT), 3, -4, 0, 0);
		w = make_word(OP_MOVE, 1'b1, 10, 1'b0, 12);
		set_entry(4, w, w, -7, 8, 10, 12);
		// Zero with axis fields that must not move
		w = make_word(OP_ZERO, 1'b0, 6, 1'b1, 6);
		set_entry(5, w, w, 0, 0, 0, 0);
		w = make_word(OP_MOVE, 1'b0, 1, 1'b1, 1);
		set_entry(6, w, w, 1, -1, 1, 1);
		w = make_word(4'd0, 1'b1, 9, 1'b1, 9);
		set_entry(7, w, with_opcode(w, OP_REJECT), 1, -1, 0, 0);
		// Negative zero on joint 1
		w = make_word(OP_MOVE, 1'b1, 0, 1'b0, 9);
		set_entry(8, w, w, 1, 8, 0, 9);
		w = make_word(OP_MOVE, 1'b0, 3, 1'b1, 2);
		set_entry(9, w, w, 4, 6, 3, 2);
	endtask

	// ==============================
	// Step pulse monitor
	// ==============================

	// Rising step seen between edges, dir checked at each pulse
	always @(negedge CLOCK_50) begin
		if (joint1_step && !step1_prev) begin
			pulse_count1 = pulse_count1 + 1;
			check_value("joint1_dir", 32'(joint1_dir), 32'(exp_dir1));
		end
		if (joint2_step && !step2_prev) begin
			pulse_count2 = pulse_count2 + 1;
			check_value("joint2_dir", 32'(joint2_dir), 32'(exp_dir2));
		end
		step1_prev = joint1_step;
		step2_prev = joint2_step;
	end

	// ==============================
	// One table row
	// ==============================

	task automatic run_entry(input int idx);
		int gap;
		int stall;
		int waited;
		int start1;
		int start2;
		cmd_word_t held;

		draw_bits(4, gap);
		repeat (gap) @(negedge CLOCK_50);
		start1   = pulse_count1;
		start2   = pulse_count2;
		exp_dir1 = tbl_cmd[idx][AXIS1_LSB + AXIS_DIR_BIT];
		exp_dir2 = tbl_cmd[idx][AXIS2_LSB + AXIS_DIR_BIT];
		@(negedge CLOCK_50);
		cmd_data  = tbl_cmd[idx];
		cmd_valid = 1'b1;
		waited = 0;
		while (!cmd_ready && waited < READY_TIMEOUT) begin
			@(negedge CLOCK_50);
			waited++;
		end
		if (!cmd_ready) begin
			$display("Timeout: command %0d was never accepted", idx);
			errors++;
			timed_out = 1'b1;
			return;
		end
		// Accepting edge comes before this falling edge
		@(negedge CLOCK_50);
		cmd_valid = 1'b0;
		waited = 1;
		while (!rsp_valid && waited < RSP_TIMEOUT) begin
			check_value("cmd_ready", 32'(cmd_ready), 32'd0);
			@(negedge CLOCK_50);
			waited++;
		end
		if (!rsp_valid) begin
			$display("Timeout: no response for command %0d", idx);
			errors++;
			timed_out = 1'b1;
			return;
		end
		// Rising edges between accept and rsp_valid high
		if (tbl_cmd[idx][OPCODE_LSB +: OPCODE_W] != OP_MOVE) begin
			check_value("rsp_latency", 32'(waited - 1), 32'd2);
		end
		check_value("rsp_data", rsp_data, tbl_rsp[idx]);
		held = rsp_data;

		// Back-pressure stall
		draw_bits(3, stall);
		for (int k = 0; k < stall; k++) begin
			@(negedge CLOCK_50);
			check_value("rsp_valid", 32'(rsp_valid), 32'd1);
			check_value("rsp_data", rsp_data, held);
			check_value("cmd_ready", 32'(cmd_ready), 32'd0);
		end
		rsp_ready = 1'b1;
		@(negedge CLOCK_50);
		rsp_ready = 1'b0;
		check_value("rsp_valid", 32'(rsp_valid), 32'd0);
		check_value("cmd_ready", 32'(cmd_ready), 32'd1);

		check_value("joint1_position", 32'(joint1_position), 32'(tbl_pos1[idx]));
		check_value("joint2_position", 32'(joint2_position), 32'(tbl_pos2[idx]));
		check_value("joint1_step count", 32'(pulse_count1 - start1), 32'(tbl_steps1[idx]));
		check_value("joint2_step count", 32'(pulse_count2 - start2), 32'(tbl_steps2[idx]));
	endtask

	// ==============================
	// Main sequence
	// ==============================

	initial begin
		int waited;
		cmd_data   = '0;
		cmd_valid  = 1'b0;
		rsp_ready  = 1'b0;
		exp_dir1   = 1'b0;
		exp_dir2   = 1'b0;
		lfsr_state = LFSR_SEED;
		fill_table();
		waited = 0;
		while (rst_n !== 1'b1 && waited < RESET_TIMEOUT) begin
			@(posedge CLOCK_50);
			waited++;
		end
		if (rst_n !== 1'b1) begin
			$display("Timeout: reset was never released");
			errors++;
		end else begin
			// Reset state
			@(negedge CLOCK_50);
			check_value("rsp_valid", 32'(rsp_valid), 32'd0);
			check_value("joint1_step", 32'(joint1_step), 32'd0);
			check_value("joint2_step", 32'(joint2_step), 32'd0);
			check_value("joint1_position", 32'(joint1_position), 32'd0);
			check_value("joint2_position", 32'(joint2_position), 32'd0);
			check_value("cmd_ready", 32'(cmd_ready), 32'd1);
			for (int i = 0; i < NUM_ENTRIES; i++) begin
				if (!timed_out) begin
					run_entry(i);
				end
			end
		end
		$display("Checks: %0d  Errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule : tb_scara_motion_top

//--- src.f
src/scara_pkg.sv
src/stepper_joint.sv
src/move_sequencer.sv
src/scara_motion_top.sv
testbench/tb_clock_gen.sv
testbench/tb_scara_motion_top.sv

//--- Makefile
# Verilator build and run for the SCARA motion testbench

SHELL     := /bin/bash

TOP       ?= tb_scara_motion_top
SIM_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= src.f
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/10ps

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(SIM_DIR) -f $(FILELIST)

run: compile
	set -o pipefail; ./$(SIM_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "Simulation reported errors, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(SIM_DIR) $(LOG)
